/* hdl/cpuPkg.sv */
package cpuPkg;

    localparam int xlen      = 32;
    localparam int regAddrW  = 5;
    localparam int imemDepth = 256;
    localparam int dmemDepth = 256;
    localparam int imemAddrW = $clog2(imemDepth);
    localparam int dmemAddrW = $clog2(dmemDepth);

    // Major opcodes of the supported subset
    localparam logic [6:0] opR      = 7'b0110011;
    localparam logic [6:0] opImm    = 7'b0010011;
    localparam logic [6:0] opLoad   = 7'b0000011;
    localparam logic [6:0] opStore  = 7'b0100011;
    localparam logic [6:0] opBranch = 7'b1100011;

    // funct3 of the register ALU ops
    localparam logic [2:0] f3AddSub = 3'b000;
    localparam logic [2:0] f3Slt    = 3'b010;
    localparam logic [2:0] f3Xor    = 3'b100;
    localparam logic [2:0] f3Or     = 3'b110;
    localparam logic [2:0] f3And    = 3'b111;

    typedef enum logic [3:0] {
        aluAdd,
        aluSub,
        aluAnd,
        aluOr,
        aluXor,
        aluSlt
    } aluOp_t;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } rType_t;

    typedef struct packed {
        logic [11:0] imm11_0;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } iType_t;

    typedef struct packed {
        logic [6:0] imm11_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm4_0;
        logic [6:0] opcode;
    } sType_t;

    // Branch offset bits are scattered, bit 0 is implied zero
    typedef struct packed {
        logic       imm12;
        logic [5:0] imm10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm4_1;
        logic       imm11;
        logic [6:0] opcode;
    } bType_t;

    typedef union packed {
        rType_t rType;
        iType_t iType;
        sType_t sType;
        bType_t bType;
    } instr_t;

    // ADDI x0,x0,0
    localparam instr_t nopInstr = 32'h0000_0013;

endpackage

/* hdl/fetchStage.sv */
module fetchStage (
    input  logic                           clk,
    input  logic                           arstN,
    input  logic                           progWrEn,
    input  logic [cpuPkg::imemAddrW-1:0]   progAddr,
    input  logic [cpuPkg::xlen-1:0]        progData,
    input  logic                           stall,
    input  logic                           branchTaken,
    input  logic [cpuPkg::xlen-1:0]        branchTarget,
    output logic [cpuPkg::xlen-1:0]        ifPc,
    output cpuPkg::instr_t                 ifInstr
);

    logic [cpuPkg::xlen-1:0] pc;
    logic [cpuPkg::xlen-1:0] fetchWord;
    logic [cpuPkg::xlen-1:0] imem [cpuPkg::imemDepth];

    // Loader writes one word per cycle
    always_ff @(posedge clk) begin
        if (progWrEn) begin
            imem[progAddr] <= progData;
        end
    end

    // Word address of the PC
    assign fetchWord = imem[pc[cpuPkg::imemAddrW+1:2]];

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            pc <= '0;
        end else if (branchTaken) begin
            pc <= branchTarget;
        end else if (!stall) begin
            pc <= pc + cpuPkg::xlen'(4);
        end
    end

    // IF/ID, holds on stall, squashed by a taken branch
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            ifPc    <= '0;
            ifInstr <= cpuPkg::nopInstr;
        end else if (branchTaken) begin
            ifPc    <= '0;
            ifInstr <= cpuPkg::nopInstr;
        end else if (!stall) begin
            ifPc    <= pc;
            ifInstr <= fetchWord;
        end
    end

    // Program memory may only change while the core is in reset
    progLoadInReset: assert property (@(posedge clk) arstN |-> !progWrEn)
        else $error("progWrEn high while the core is running");

endmodule

/* hdl/decodeStage.sv */
module decodeStage (
    input  logic                           clk,
    input  logic                           arstN,
    input  logic [cpuPkg::xlen-1:0]        ifPc,
    input  cpuPkg::instr_t                 ifInstr,
    input  logic                           branchTaken,
    input  logic [cpuPkg::regAddrW-1:0]    wbRd,
    input  logic                           wbRegWrite,
    input  logic [cpuPkg::xlen-1:0]        wbData,
    output logic                           stall,
    output logic [cpuPkg::regAddrW-1:0]    idRs1,
    output logic [cpuPkg::regAddrW-1:0]    idRs2,
    output logic [cpuPkg::regAddrW-1:0]    idRd,
    output logic                           idRegWrite,
    output logic                           idMemRead,
    output logic                           idMemWrite,
    output logic                           idMemToReg,
    output cpuPkg::aluOp_t                 idAluOp,
    output logic                           idAluSrc,
    output logic                           idBranch,
    output logic [cpuPkg::xlen-1:0]        idImm,
    output logic [cpuPkg::xlen-1:0]        idPc,
    output logic [cpuPkg::xlen-1:0]        idRs1Data,
    output logic [cpuPkg::xlen-1:0]        idRs2Data
);

    logic [6:0]                  opcode;
    logic [cpuPkg::regAddrW-1:0] rs1;
    logic [cpuPkg::regAddrW-1:0] rs2;
    logic                        usesRs2;
    logic                        regWrite;
    logic                        memRead;
    logic                        memWrite;
    logic                        memToReg;
    logic                        aluSrc;
    logic                        branch;
    cpuPkg::aluOp_t              aluOp;
    logic [cpuPkg::xlen-1:0]     imm;
    logic [cpuPkg::xlen-1:0]     rs1Data;
    logic [cpuPkg::xlen-1:0]     rs2Data;
    logic                        bubble;
    logic [cpuPkg::xlen-1:0]     regs [2**cpuPkg::regAddrW];

    assign opcode  = ifInstr.rType.opcode;
    assign rs1     = ifInstr.rType.rs1;
    assign usesRs2 = opcode == cpuPkg::opR || opcode == cpuPkg::opStore ||
                     opcode == cpuPkg::opBranch;
    // I-format keeps immediate bits in the rs2 field
    assign rs2     = usesRs2 ? ifInstr.rType.rs2 : '0;

    always_comb begin
        regWrite = 1'b0;
        memRead  = 1'b0;
        memWrite = 1'b0;
        memToReg = 1'b0;
        aluSrc   = 1'b0;
        branch   = 1'b0;
        aluOp    = cpuPkg::aluAdd;
        imm      = '0;
        case (opcode)
            cpuPkg::opR: begin
                regWrite = 1'b1;
                case (ifInstr.rType.funct3)
                    cpuPkg::f3AddSub: aluOp = ifInstr.rType.funct7[5] ? cpuPkg::aluSub
                                                                      : cpuPkg::aluAdd;
                    cpuPkg::f3Slt:    aluOp = cpuPkg::aluSlt;
                    cpuPkg::f3Xor:    aluOp = cpuPkg::aluXor;
                    cpuPkg::f3Or:     aluOp = cpuPkg::aluOr;
                    cpuPkg::f3And:    aluOp = cpuPkg::aluAnd;
                    default:          aluOp = cpuPkg::aluAdd;
                endcase
            end
            cpuPkg::opImm, cpuPkg::opLoad: begin
                regWrite = 1'b1;
                aluSrc   = 1'b1;
                memRead  = opcode == cpuPkg::opLoad;
                memToReg = opcode == cpuPkg::opLoad;
                imm      = {{20{ifInstr.iType.imm11_0[11]}}, ifInstr.iType.imm11_0};
            end
            cpuPkg::opStore: begin
                memWrite = 1'b1;
                aluSrc   = 1'b1;
                imm      = {{20{ifInstr.sType.imm11_5[6]}}, ifInstr.sType.imm11_5,
                            ifInstr.sType.imm4_0};
            end
            cpuPkg::opBranch: begin
                branch = 1'b1;
                imm    = {{19{ifInstr.bType.imm12}}, ifInstr.bType.imm12,
                          ifInstr.bType.imm11, ifInstr.bType.imm10_5,
                          ifInstr.bType.imm4_1, 1'b0};
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk) begin
        if (wbRegWrite && wbRd != '0) begin
            regs[wbRd] <= wbData;
        end
    end

    // x0 reads zero and the writeback value is bypassed in the same cycle
    assign rs1Data = (rs1 == '0) ? '0 :
                     (wbRegWrite && wbRd == rs1) ? wbData : regs[rs1];
    assign rs2Data = (rs2 == '0) ? '0 :
                     (wbRegWrite && wbRd == rs2) ? wbData : regs[rs2];

    // Load in ID/EX feeding the instruction in decode
    assign stall  = idMemRead && idRd != '0 && (idRd == rs1 || idRd == rs2);
    assign bubble = stall || branchTaken;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            idRs1      <= '0;
            idRs2      <= '0;
            idRd       <= '0;
            idRegWrite <= 1'b0;
            idMemRead  <= 1'b0;
            idMemWrite <= 1'b0;
            idMemToReg <= 1'b0;
            idBranch   <= 1'b0;
        end else begin
            idRs1      <= bubble ? '0 : rs1;
            idRs2      <= bubble ? '0 : rs2;
            idRd       <= bubble ? '0 : ifInstr.rType.rd;
            idRegWrite <= regWrite && !bubble;
            idMemRead  <= memRead && !bubble;
            idMemWrite <= memWrite && !bubble;
            idMemToReg <= memToReg && !bubble;
            idBranch   <= branch && !bubble;
        end
    end

    always_ff @(posedge clk) begin
        idAluOp   <= aluOp;
        idAluSrc  <= aluSrc;
        idImm     <= imm;
        idPc      <= ifPc;
        idRs1Data <= rs1Data;
        idRs2Data <= rs2Data;
    end

    // A stalled instruction is still in decode one cycle later
    stallHoldsDecode: assert property (@(posedge clk) disable iff (!arstN)
        (stall && !branchTaken) |=> ($stable(ifInstr) && $stable(ifPc)))
        else $error("stalled instruction left decode");

endmodule

/* hdl/executeStage.sv */
module executeStage (
    input  logic                           clk,
    input  logic                           arstN,
    input  logic [cpuPkg::regAddrW-1:0]    idRs1,
    input  logic [cpuPkg::regAddrW-1:0]    idRs2,
    input  logic [cpuPkg::regAddrW-1:0]    idRd,
    input  logic                           idRegWrite,
    input  logic                           idMemRead,
    input  logic                           idMemWrite,
    input  logic                           idMemToReg,
    input  cpuPkg::aluOp_t                 idAluOp,
    input  logic                           idAluSrc,
    input  logic                           idBranch,
    input  logic [cpuPkg::xlen-1:0]        idImm,
    input  logic [cpuPkg::xlen-1:0]        idPc,
    input  logic [cpuPkg::xlen-1:0]        idRs1Data,
    input  logic [cpuPkg::xlen-1:0]        idRs2Data,
    input  logic [cpuPkg::regAddrW-1:0]    wbRd,
    input  logic                           wbRegWrite,
    input  logic [cpuPkg::xlen-1:0]        wbData,
    output logic                           branchTaken,
    output logic [cpuPkg::xlen-1:0]        branchTarget,
    output logic [cpuPkg::xlen-1:0]        exResult,
    output logic [cpuPkg::xlen-1:0]        exStoreData,
    output logic [cpuPkg::regAddrW-1:0]    exRd,
    output logic                           exRegWrite,
    output logic                           exMemRead,
    output logic                           exMemWrite,
    output logic                           exMemToReg
);

    logic [cpuPkg::xlen-1:0] opA;
    logic [cpuPkg::xlen-1:0] fwdB;
    logic [cpuPkg::xlen-1:0] opB;
    logic [cpuPkg::xlen-1:0] aluResult;

    // Youngest producer wins and x0 is never forwarded
    function automatic logic [cpuPkg::xlen-1:0] forward(
        input logic [cpuPkg::regAddrW-1:0] rs,
        input logic [cpuPkg::xlen-1:0]     regVal
    );
        if (rs != '0 && exRegWrite && exRd == rs) begin
            return exResult;
        end else if (rs != '0 && wbRegWrite && wbRd == rs) begin
            return wbData;
        end
        return regVal;
    endfunction

    always_comb begin
        opA  = forward(idRs1, idRs1Data);
        fwdB = forward(idRs2, idRs2Data);
    end

    assign opB = idAluSrc ? idImm : fwdB;

    always_comb begin
        case (idAluOp)
            cpuPkg::aluAdd: aluResult = opA + opB;
            cpuPkg::aluSub: aluResult = opA - opB;
            cpuPkg::aluAnd: aluResult = opA & opB;
            cpuPkg::aluOr:  aluResult = opA | opB;
            cpuPkg::aluXor: aluResult = opA ^ opB;
            cpuPkg::aluSlt: aluResult = {31'd0, $signed(opA) < $signed(opB)};
            default:        aluResult = opA + opB;
        endcase
    end

    // BEQ resolves here
    assign branchTaken  = idBranch && (opA == fwdB);
    assign branchTarget = idPc + idImm;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            exRd       <= '0;
            exRegWrite <= 1'b0;
            exMemRead  <= 1'b0;
            exMemWrite <= 1'b0;
            exMemToReg <= 1'b0;
        end else begin
            exRd       <= idRd;
            exRegWrite <= idRegWrite;
            exMemRead  <= idMemRead;
            exMemWrite <= idMemWrite;
            exMemToReg <= idMemToReg;
        end
    end

    always_ff @(posedge clk) begin
        exResult    <= aluResult;
        exStoreData <= fwdB;
    end

    // Slot behind a taken branch is flushed and cannot redirect again
    noRedirectBehindBranch: assert property (@(posedge clk) disable iff (!arstN)
        branchTaken |=> !branchTaken)
        else $error("redirect from the slot behind a taken branch");

endmodule

/* hdl/memoryStage.sv */
module memoryStage (
    input  logic                           clk,
    input  logic                           arstN,
    input  logic [cpuPkg::xlen-1:0]        exResult,
    input  logic [cpuPkg::xlen-1:0]        exStoreData,
    input  logic [cpuPkg::regAddrW-1:0]    exRd,
    input  logic                           exRegWrite,
    input  logic                           exMemRead,
    input  logic                           exMemWrite,
    input  logic                           exMemToReg,
    output logic [cpuPkg::regAddrW-1:0]    wbRd,
    output logic                           wbRegWrite,
    output logic                           wbMemToReg,
    output logic [cpuPkg::xlen-1:0]        wbLoadData,
    output logic [cpuPkg::xlen-1:0]        wbAluResult
);

    logic [cpuPkg::dmemAddrW-1:0] wordAddr;
    logic [cpuPkg::xlen-1:0]      loadData;
    logic [cpuPkg::xlen-1:0]      dmem [cpuPkg::dmemDepth];

    // Word access only, low two bits ignored
    assign wordAddr = exResult[cpuPkg::dmemAddrW+1:2];

    always_ff @(posedge clk) begin
        if (exMemWrite) begin
            dmem[wordAddr] <= exStoreData;
        end
    end

    assign loadData = exMemRead ? dmem[wordAddr] : '0;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            wbRd       <= '0;
            wbRegWrite <= 1'b0;
            wbMemToReg <= 1'b0;
        end else begin
            wbRd       <= exRd;
            wbRegWrite <= exRegWrite;
            wbMemToReg <= exMemToReg;
        end
    end

    // MEM/WB payload
    always_ff @(posedge clk) begin
        wbLoadData  <= loadData;
        wbAluResult <= exResult;
    end

endmodule

/* hdl/topCpu.sv */
module topCpu (
    input  logic                           clk,
    input  logic                           arstN,
    input  logic                           progWrEn,
    input  logic [cpuPkg::imemAddrW-1:0]   progAddr,
    input  logic [cpuPkg::xlen-1:0]        progData,
    output logic                           retireValid,
    output logic [cpuPkg::regAddrW-1:0]    retireRd,
    output logic [cpuPkg::xlen-1:0]        retireData
);

    // IF to ID
    logic [cpuPkg::xlen-1:0]     ifPc;
    cpuPkg::instr_t              ifInstr;
    logic                        stall;
    logic                        branchTaken;
    logic [cpuPkg::xlen-1:0]     branchTarget;

    // ID to EX
    logic [cpuPkg::regAddrW-1:0] idRs1;
    logic [cpuPkg::regAddrW-1:0] idRs2;
    logic [cpuPkg::regAddrW-1:0] idRd;
    logic                        idRegWrite;
    logic                        idMemRead;
    logic                        idMemWrite;
    logic                        idMemToReg;
    cpuPkg::aluOp_t              idAluOp;
    logic                        idAluSrc;
    logic                        idBranch;
    logic [cpuPkg::xlen-1:0]     idImm;
    logic [cpuPkg::xlen-1:0]     idPc;
    logic [cpuPkg::xlen-1:0]     idRs1Data;
    logic [cpuPkg::xlen-1:0]     idRs2Data;

    // EX to MEM
    logic [cpuPkg::xlen-1:0]     exResult;
    logic [cpuPkg::xlen-1:0]     exStoreData;
    logic [cpuPkg::regAddrW-1:0] exRd;
    logic                        exRegWrite;
    logic                        exMemRead;
    logic                        exMemWrite;
    logic                        exMemToReg;

    // MEM to WB
    logic [cpuPkg::regAddrW-1:0] wbRd;
    logic                        wbRegWrite;
    logic                        wbMemToReg;
    logic [cpuPkg::xlen-1:0]     wbLoadData;
    logic [cpuPkg::xlen-1:0]     wbAluResult;
    logic [cpuPkg::xlen-1:0]     wbData;

    fetchStage uFetch (.*);

    decodeStage uDecode (.*);

    executeStage uExecute (.*);

    memoryStage uMemory (.*);

    // Writeback select
    assign wbData = wbMemToReg ? wbLoadData : wbAluResult;

    // Writes to x0 are not architectural, so they do not retire
    assign retireValid = wbRegWrite && wbRd != '0;
    assign retireRd    = wbRd;
    assign retireData  = wbData;

endmodule

/* testbench/tbTopCpu.sv */
module tbTopCpu;

    localparam int resetCycles  = 10;
    localparam int maxProgWords = 40;
    localparam int settleCycles = 8;
    localparam int numTests     = 5;
    // Loading plus running a full-length program plus slack
    localparam int testBudget   = resetCycles + 2 * maxProgWords + 20;

    logic                           clk;
    logic                           arstN;
    logic                           progWrEn;
    logic [cpuPkg::imemAddrW-1:0]   progAddr;
    logic [cpuPkg::xlen-1:0]        progData;
    logic                           retireValid;
    logic [cpuPkg::regAddrW-1:0]    retireRd;
    logic [cpuPkg::xlen-1:0]        retireData;

    logic [31:0]                 lfsr = 32'hcb9e_6e11;
    cpuPkg::instr_t              prog [$];
    logic [cpuPkg::regAddrW-1:0] expRd [$];
    logic [cpuPkg::xlen-1:0]     expData [$];
    logic [cpuPkg::regAddrW-1:0] gotRd [$];
    logic [cpuPkg::xlen-1:0]     gotData [$];
    int                          gotCycle [$];
    int                          relCycle = 0;
    int                          skipCount;
    // Architectural state kept across tests like the DUT's
    logic [cpuPkg::xlen-1:0]     model [32] = '{default: '0};
    logic [cpuPkg::xlen-1:0]     modelMem [logic [29:0]];

    topCpu UUT (.*);

    always #5 clk = ~clk;

    task automatic abortRun();
        $display("Finished with errors");
        $fatal(1);
    endtask

    // Retire monitor samples mid-cycle
    // Cycle 0 is the first cycle after reset release
    always @(negedge clk) begin
        if (!arstN) begin
            relCycle <= 0;
            if (retireValid) begin
                $display("retireValid was high while reset was asserted");
                abortRun();
            end
        end else begin
            relCycle <= relCycle + 1;
            if (retireValid) begin
                gotRd.push_back(retireRd);
                gotData.push_back(retireData);
                gotCycle.push_back(relCycle);
            end
        end
    end

    task automatic checkRd(input string name, input logic [cpuPkg::regAddrW-1:0] exp,
                           input logic [cpuPkg::regAddrW-1:0] act);
        if (act !== exp) begin
            $display("Mismatch in %s: expected rd x%0d, got x%0d", name, exp, act);
            abortRun();
        end
    endtask

    task automatic checkData(input string name, input logic [cpuPkg::xlen-1:0] exp,
                             input logic [cpuPkg::xlen-1:0] act);
        if (act !== exp) begin
            $display("Mismatch in %s: expected data %h, got %h", name, exp, act);
            abortRun();
        end
    endtask

    task automatic checkCount(input string name, input int exp, input int act);
        if (act != exp) begin
            $display("Mismatch in %s: expected %0d, got %0d", name, exp, act);
            abortRun();
        end
    endtask

    // Fibonacci LFSR with taps 32 22 2 1
    function automatic logic [11:0] randImm();
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < 12; i++) begin
            lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
            v = {v[30:0], lfsr[0]};
        end
        return v[11:0];
    endfunction

    function automatic logic [cpuPkg::xlen-1:0] sext12(input logic [11:0] imm);
        return {{20{imm[11]}}, imm};
    endfunction

    function automatic cpuPkg::instr_t encR(input logic [6:0] f7, input logic [4:0] s2,
                                            input logic [4:0] s1, input logic [2:0] f3,
                                            input logic [4:0] rd);
        cpuPkg::instr_t w;
        w.rType = '{f7, s2, s1, f3, rd, cpuPkg::opR};
        return w;
    endfunction

    function automatic cpuPkg::instr_t encI(input logic [6:0] op, input logic [2:0] f3,
                                            input logic [4:0] rd, input logic [4:0] s1,
                                            input logic [11:0] imm);
        cpuPkg::instr_t w;
        w.iType = '{imm, s1, f3, rd, op};
        return w;
    endfunction

    function automatic cpuPkg::instr_t encS(input logic [4:0] s2, input logic [4:0] s1,
                                            input logic [11:0] imm);
        cpuPkg::instr_t w;
        w.sType = '{imm[11:5], s2, s1, 3'b010, imm[4:0], cpuPkg::opStore};
        return w;
    endfunction

    function automatic cpuPkg::instr_t encB(input logic [4:0] s1, input logic [4:0] s2,
                                            input logic [12:0] off);
        cpuPkg::instr_t w;
        w.bType = '{off[12], off[10:5], s2, s1, 3'b000, off[4:1], off[11], cpuPkg::opBranch};
        return w;
    endfunction

    // Appends a word and returns 0 when a taken branch skips it
    function automatic bit emit(input cpuPkg::instr_t w);
        prog.push_back(w);
        if (skipCount > 0) begin
            skipCount--;
            return 1'b0;
        end
        return 1'b1;
    endfunction

    task automatic retireModel(input logic [cpuPkg::regAddrW-1:0] rd,
                               input logic [cpuPkg::xlen-1:0] val);
        if (rd != '0) begin
            model[rd] = val;
            expRd.push_back(rd);
            expData.push_back(val);
        end
    endtask

    task automatic emitAddi(input logic [cpuPkg::regAddrW-1:0] rd,
                            input logic [cpuPkg::regAddrW-1:0] rs1, input logic [11:0] imm);
        if (emit(encI(cpuPkg::opImm, 3'b000, rd, rs1, imm))) begin
            retireModel(rd, model[rs1] + sext12(imm));
        end
    endtask

    task automatic emitNop();
        emitAddi(0, 0, 12'd0);
    endtask

    task automatic emitR(input cpuPkg::aluOp_t op, input logic [cpuPkg::regAddrW-1:0] rd,
                         input logic [cpuPkg::regAddrW-1:0] rs1,
                         input logic [cpuPkg::regAddrW-1:0] rs2);
        logic [2:0]              f3;
        logic [6:0]              f7;
        logic [cpuPkg::xlen-1:0] a;
        logic [cpuPkg::xlen-1:0] b;
        logic [cpuPkg::xlen-1:0] r;
        a  = model[rs1];
        b  = model[rs2];
        f7 = 7'h00;
        // funct3 and funct7 as in the RV32I base encoding
        case (op)
            cpuPkg::aluAdd: begin
                f3 = 3'b000;
                r  = a + b;
            end
            cpuPkg::aluSub: begin
                f3 = 3'b000;
                f7 = 7'h20;
                r  = a - b;
            end
            cpuPkg::aluAnd: begin
                f3 = 3'b111;
                r  = a & b;
            end
            cpuPkg::aluOr: begin
                f3 = 3'b110;
                r  = a | b;
            end
            cpuPkg::aluXor: begin
                f3 = 3'b100;
                r  = a ^ b;
            end
            default: begin
                f3 = 3'b010;
                r  = cpuPkg::xlen'($signed(a) < $signed(b));
            end
        endcase
        if (emit(encR(f7, rs2, rs1, f3, rd))) begin
            retireModel(rd, r);
        end
    endtask

    task automatic emitLw(input logic [cpuPkg::regAddrW-1:0] rd,
                          input logic [cpuPkg::regAddrW-1:0] rs1, input logic [11:0] imm);
        logic [cpuPkg::xlen-1:0] addr;
        addr = model[rs1] + sext12(imm);
        if (emit(encI(cpuPkg::opLoad, 3'b010, rd, rs1, imm))) begin
            retireModel(rd, modelMem[addr[31:2]]);
        end
    endtask

    task automatic emitSw(input logic [cpuPkg::regAddrW-1:0] rs2,
                          input logic [cpuPkg::regAddrW-1:0] rs1, input logic [11:0] imm);
        logic [cpuPkg::xlen-1:0] addr;
        addr = model[rs1] + sext12(imm);
        if (emit(encS(rs2, rs1, imm))) begin
            modelMem[addr[31:2]] = model[rs2];
        end
    endtask

    // Offset 12 jumps over the next two words
    task automatic emitBeq(input logic [cpuPkg::regAddrW-1:0] rs1,
                           input logic [cpuPkg::regAddrW-1:0] rs2);
        if (emit(encB(rs1, rs2, 13'd12)) && model[rs1] == model[rs2]) begin
            skipCount = 2;
        end
    endtask

    task automatic clearProgram();
        prog.delete();
        expRd.delete();
        expData.delete();
        skipCount = 0;
    endtask

    task automatic runProgram(input string name);
        int i;
        // Park on BEQ x0,x0,0 with NOP padding behind it
        prog.push_back(encB(0, 0, 13'd0));
        prog.push_back(encI(cpuPkg::opImm, 3'b000, 0, 0, 12'd0));
        prog.push_back(encI(cpuPkg::opImm, 3'b000, 0, 0, 12'd0));
        for (i = 0; i < prog.size() || i < resetCycles; i++) begin
            @(posedge clk);
            arstN    <= 1'b0;
            progWrEn <= i < prog.size();
            progAddr <= cpuPkg::imemAddrW'(i);
            progData <= (i < prog.size()) ? prog[i] : '0;
        end
        gotRd.delete();
        gotData.delete();
        gotCycle.delete();
        @(posedge clk);
        progWrEn <= 1'b0;
        arstN    <= 1'b1;
        while (gotRd.size() < expRd.size()) begin
            @(posedge clk);
        end
        // Room for a squashed instruction to show up if the flush failed
        repeat (settleCycles) @(posedge clk);
        checkCount({name, " retire count"}, expRd.size(), gotRd.size());
        for (i = 0; i < expRd.size(); i++) begin
            checkRd(name, expRd[i], gotRd[i]);
            checkData(name, expData[i], gotData[i]);
        end
    endtask

    task automatic testAlu();
        cpuPkg::aluOp_t ops [6];
        ops = '{cpuPkg::aluAdd, cpuPkg::aluSub, cpuPkg::aluAnd,
                cpuPkg::aluOr, cpuPkg::aluXor, cpuPkg::aluSlt};
        clearProgram();
        emitAddi(1, 0, randImm());
        emitAddi(2, 0, randImm());
        repeat (3) emitNop();
        for (int k = 0; k < 6; k++) begin
            emitR(ops[k], cpuPkg::regAddrW'(3 + k), 1, 2);
            emitNop();
        end
        emitR(cpuPkg::aluSlt, 9, 2, 1);
        runProgram("alu");
    endtask

    task automatic testForward();
        clearProgram();
        emitAddi(5, 0, randImm());
        emitR(cpuPkg::aluAdd, 6, 5, 5);
        emitR(cpuPkg::aluSub, 7, 6, 5);
        // Write to x0 right before a read of x0
        emitAddi(0, 7, randImm());
        emitR(cpuPkg::aluAdd, 8, 0, 7);
        emitR(cpuPkg::aluXor, 9, 8, 6);
        emitR(cpuPkg::aluOr, 10, 9, 9);
        emitR(cpuPkg::aluSlt, 11, 10, 5);
        emitR(cpuPkg::aluAnd, 12, 11, 10);
        runProgram("forward");
    endtask

    task automatic testLoadStore();
        clearProgram();
        emitAddi(13, 0, 12'd64);
        emitAddi(14, 0, randImm());
        emitAddi(15, 0, randImm());
        emitSw(14, 13, 12'd0);
        emitSw(15, 13, 12'd8);
        emitSw(15, 0, 12'd40);
        emitLw(16, 13, 12'd0);
        emitR(cpuPkg::aluAdd, 17, 16, 15);
        emitLw(18, 13, 12'd8);
        emitLw(19, 0, 12'd40);
        emitR(cpuPkg::aluSub, 20, 19, 18);
        emitSw(16, 13, 12'd12);
        emitLw(21, 13, 12'd12);
        emitSw(21, 13, 12'd24);
        emitLw(1, 13, 12'd24);
        emitAddi(22, 0, randImm());
        emitSw(22, 13, 12'd20);
        emitLw(23, 13, 12'd20);
        runProgram("load store");
    endtask

    task automatic testBranch();
        clearProgram();
        emitAddi(24, 0, randImm());
        emitAddi(25, 24, 12'd0);
        emitBeq(24, 25);
        emitAddi(26, 0, 12'd1);
        emitAddi(27, 0, 12'd2);
        emitAddi(28, 24, 12'd3);
        emitAddi(29, 24, 12'd1);
        emitBeq(24, 29);
        emitAddi(26, 0, 12'd5);
        emitAddi(27, 0, 12'd6);
        emitBeq(26, 26);
        emitAddi(28, 0, 12'd7);
        emitAddi(29, 0, 12'd8);
        emitAddi(3, 27, 12'd1);
        runProgram("branch");
    endtask

    task automatic testReset();
        clearProgram();
        emitAddi(30, 0, randImm());
        emitAddi(31, 30, 12'd1);
        runProgram("reset");
        checkCount("reset first retire cycle", 4, gotCycle[0]);
    endtask

    initial begin
        repeat (numTests * testBudget) @(posedge clk);
        $display("Watchdog expired, retirement stalled");
        abortRun();
    end

    initial begin
        clk      = 1'b0;
        arstN    = 1'b0;
        progWrEn = 1'b0;
        progAddr = '0;
        progData = '0;
        testAlu();
        testForward();
        testLoadStore();
        testBranch();
        testReset();
        $display("Finished with no errors");
        $finish;
    end

endmodule

/* topCpu.f */
hdl/cpuPkg.sv
hdl/fetchStage.sv
hdl/decodeStage.sv
hdl/executeStage.sv
hdl/memoryStage.sv
hdl/topCpu.sv
testbench/tbTopCpu.sv

/* Makefile */
VERILATOR ?= verilator
FLAGS     ?= -sv --timing --assert
TOP       ?= tbTopCpu
RTL_TOP   ?= topCpu
FILELIST  ?= topCpu.f
PASS_MSG  := Finished with no errors

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(FLAGS) --lint-only --top-module $(RTL_TOP) -f $(FILELIST)
	$(VERILATOR) $(FLAGS) --lint-only --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(FLAGS) --binary --top-module $(TOP) -f $(FILELIST) -o $(TOP)
	./obj_dir/$(TOP) | tee /dev/stderr | grep -F -q "$(PASS_MSG)"

clean:
	rm -rf obj_dir
